//--- Makefile
# Verilator build and run for the Avalon-MM to AXI4-Lite subsystem

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(abspath $(BIN)))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- common/axil_if.sv
// --------------------
// AXI4-Lite channel bundle between bridge and register block
// --------------------
interface axil_if;

  // Write address and data
  logic                             awvalid;
  logic                             awready;
  logic [bridge_pkg::ADDR_W-1:0]    awaddr;
  logic                             wvalid;
  logic                             wready;
  logic [bridge_pkg::DATA_W-1:0]    wdata;
  logic [bridge_pkg::STRB_W-1:0]    wstrb;

  // Write response
  logic                             bvalid;
  logic                             bready;
  logic [1:0]                       bresp;

  // Read address and data
  logic                             arvalid;
  logic                             arready;
  logic [bridge_pkg::ADDR_W-1:0]    araddr;
  logic                             rvalid;
  logic                             rready;
  logic [bridge_pkg::DATA_W-1:0]    rdata;
  logic [1:0]                       rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

//--- common/bridge_pkg.sv
// --------------------
// Shared widths, register map and control field layout
// --------------------
package bridge_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // --------------------
  // Register map
  // --------------------
  // Word index taken from address bits 3:2
  localparam logic [1:0] REG_SCRATCH0 = 2'd0;
  localparam logic [1:0] REG_SCRATCH1 = 2'd1;
  localparam logic [1:0] REG_CTRL     = 2'd2;
  // Read-only, follows the event counter
  localparam logic [1:0] REG_COUNT    = 2'd3;

  // --------------------
  // Control register fields
  // --------------------
  // Counter enable
  localparam int CTRL_EN_BIT   = 0;

  // Step added per cycle while enabled
  localparam int CTRL_STEP_LSB = 8;
  localparam int CTRL_STEP_W   = 8;

  // Writable bits, everything else reads as zero
  localparam logic [DATA_W-1:0] CTRL_MASK = 32'h0000_ff01;

  // --------------------
  // Response codes
  // --------------------
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- flist.f
common/bridge_pkg.sv
common/axil_if.sv
hw/avmm_axil_bridge/avmm_axil_bridge.sv
hw/axil_regs/axil_regs.sv
hw/event_counter.sv
hw/axil_subsys_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- hw/avmm_axil_bridge/avmm_axil_bridge.sv
// --------------------
// Avalon-MM to AXI4-Lite bridge, one command at a time
// with byte-lane alignment on the low address bits
// --------------------
module avmm_axil_bridge (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic [bridge_pkg::ADDR_W-1:0]   avmm_address_i,
  input  logic [bridge_pkg::DATA_W-1:0]   avmm_writedata_i,
  input  logic [bridge_pkg::STRB_W-1:0]   avmm_byteenable_i,
  input  logic                            avmm_read_i,
  input  logic                            avmm_write_i,
  output logic [bridge_pkg::DATA_W-1:0]   avmm_readdata_o,
  output logic                            avmm_waitrequest_o,
  output logic                            avmm_readdata_valid_o,
  axil_if.master                          axil
);

  // --------------------
  // Lane alignment
  // --------------------
  function automatic logic [bridge_pkg::DATA_W-1:0] align_wdata(
    input logic [bridge_pkg::DATA_W-1:0] data,
    input logic [1:0]                    offset
  );
    return data << (8 * offset);
  endfunction

  function automatic logic [bridge_pkg::STRB_W-1:0] align_strb(
    input logic [bridge_pkg::STRB_W-1:0] be,
    input logic [1:0]                    offset
  );
    return be << offset;
  endfunction

  // Offset 1 keeps two bytes, offset 3 keeps one
  function automatic logic [bridge_pkg::DATA_W-1:0] align_rdata(
    input logic [bridge_pkg::DATA_W-1:0] data,
    input logic [1:0]                    offset
  );
    logic [bridge_pkg::DATA_W-1:0] result;
    case (offset)
      2'd0:    result = data;
      2'd1:    result = {16'b0, data[23:8]};
      2'd2:    result = {16'b0, data[31:16]};
      default: result = {24'b0, data[31:24]};
    endcase
    return result;
  endfunction

  // --------------------
  // Command acceptance
  // --------------------
  logic                            aw_valid_q;
  logic                            w_valid_q;
  logic                            ar_valid_q;
  logic                            wr_busy_q;
  logic                            rd_busy_q;
  logic                            resp_d1_q;
  logic                            wr_accept;
  logic                            rd_accept;
  logic [bridge_pkg::ADDR_W-1:0]   addr_q;
  logic [bridge_pkg::DATA_W-1:0]   wdata_q;
  logic [bridge_pkg::STRB_W-1:0]   wstrb_q;
  logic [1:0]                      rd_offset_q;

  // A response in the last cycle blocks the host for one more cycle
  assign wr_accept = avmm_write_i & ~avmm_waitrequest_o & ~resp_d1_q;
  assign rd_accept = avmm_read_i & ~avmm_write_i & ~avmm_waitrequest_o & ~resp_d1_q;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
      wr_busy_q  <= 1'b0;
      rd_busy_q  <= 1'b0;
      resp_d1_q  <= 1'b0;
    end else begin
      resp_d1_q  <= axil.bvalid | axil.rvalid;
      aw_valid_q <= wr_accept | (aw_valid_q & ~axil.awready);
      w_valid_q  <= wr_accept | (w_valid_q & ~axil.wready);
      ar_valid_q <= rd_accept | (ar_valid_q & ~axil.arready);
      // Busy until the matching response shows up
      wr_busy_q  <= wr_accept | (wr_busy_q & ~axil.bvalid);
      rd_busy_q  <= rd_accept | (rd_busy_q & ~axil.rvalid);
    end
  end

  // Payload captured on acceptance, address shared by both directions
  always_ff @(posedge aclk) begin
    if (wr_accept | rd_accept) begin
      addr_q <= avmm_address_i;
    end
    if (wr_accept) begin
      wdata_q <= align_wdata(avmm_writedata_i, avmm_address_i[1:0]);
      wstrb_q <= align_strb(avmm_byteenable_i, avmm_address_i[1:0]);
    end
    if (rd_accept) begin
      rd_offset_q <= avmm_address_i[1:0];
    end
  end

  // --------------------
  // AXI4-Lite side
  // --------------------
  assign axil.awvalid = aw_valid_q;
  assign axil.awaddr  = addr_q;
  assign axil.wvalid  = w_valid_q;
  assign axil.wdata   = wdata_q;
  assign axil.wstrb   = wstrb_q;
  assign axil.arvalid = ar_valid_q;
  assign axil.araddr  = addr_q;
  // Never stall responses, bresp and rresp are not checked
  assign axil.bready  = 1'b1;
  assign axil.rready  = 1'b1;

  // --------------------
  // Avalon side
  // --------------------
  assign avmm_waitrequest_o    = wr_busy_q | rd_busy_q;
  assign avmm_readdata_valid_o = axil.rvalid & axil.rready;
  assign avmm_readdata_o       = align_rdata(axil.rdata, rd_offset_q);

  // New command only once the last one has fully drained
  a_accept_when_idle: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (wr_accept | rd_accept) |->
      ~(aw_valid_q | w_valid_q | ar_valid_q | axil.bvalid | axil.rvalid)
  );

  a_awvalid_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (axil.awvalid & ~axil.awready) |=> axil.awvalid & $stable(axil.awaddr)
  );

endmodule

//--- hw/axil_regs/axil_regs.sv
// --------------------
// AXI4-Lite register block, scratch, control and count status
// --------------------
module axil_regs (
  input  logic                               aclk,
  input  logic                               aresetn,
  axil_if.slave                              axil,
  input  logic [bridge_pkg::DATA_W-1:0]      count_value_i,
  output logic                               count_en_o,
  output logic [bridge_pkg::CTRL_STEP_W-1:0] count_step_o
);

  // Byte-wise merge under the write strobe
  function automatic logic [bridge_pkg::DATA_W-1:0] merge_bytes(
    input logic [bridge_pkg::DATA_W-1:0] old_val,
    input logic [bridge_pkg::DATA_W-1:0] new_val,
    input logic [bridge_pkg::STRB_W-1:0] strb
  );
    logic [bridge_pkg::DATA_W-1:0] result;
    result = old_val;
    for (int i = 0; i < bridge_pkg::STRB_W; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return result;
  endfunction

  logic [bridge_pkg::DATA_W-1:0] scratch0_q;
  logic [bridge_pkg::DATA_W-1:0] scratch1_q;
  logic [bridge_pkg::DATA_W-1:0] ctrl_q;
  logic [bridge_pkg::DATA_W-1:0] rdata_q;
  logic                          bvalid_q;
  logic                          rvalid_q;
  logic                          wr_fire;
  logic                          rd_fire;
  logic [1:0]                    wr_idx;
  logic [1:0]                    rd_idx;

  // --------------------
  // Write path
  // --------------------
  // AW and W taken together, only with no B outstanding
  assign wr_fire      = axil.awvalid & axil.wvalid & ~bvalid_q;
  assign axil.awready = wr_fire;
  assign axil.wready  = wr_fire;
  assign wr_idx       = axil.awaddr[3:2];

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      scratch0_q <= '0;
      scratch1_q <= '0;
      ctrl_q     <= '0;
      bvalid_q   <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil.bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        case (wr_idx)
          bridge_pkg::REG_SCRATCH0:
            scratch0_q <= merge_bytes(scratch0_q, axil.wdata, axil.wstrb);
          bridge_pkg::REG_SCRATCH1:
            scratch1_q <= merge_bytes(scratch1_q, axil.wdata, axil.wstrb);
          bridge_pkg::REG_CTRL:
            ctrl_q <= merge_bytes(ctrl_q, axil.wdata, axil.wstrb) & bridge_pkg::CTRL_MASK;
          // Count is read-only
          default: ;
        endcase
      end
    end
  end

  assign axil.bvalid = bvalid_q;
  assign axil.bresp  = bridge_pkg::RESP_OKAY;

  // --------------------
  // Read path
  // --------------------
  assign rd_fire      = axil.arvalid & ~rvalid_q;
  assign axil.arready = rd_fire;
  assign rd_idx       = axil.araddr[3:2];

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (axil.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      case (rd_idx)
        bridge_pkg::REG_SCRATCH0: rdata_q <= scratch0_q;
        bridge_pkg::REG_SCRATCH1: rdata_q <= scratch1_q;
        bridge_pkg::REG_CTRL:     rdata_q <= ctrl_q;
        default:                  rdata_q <= count_value_i;
      endcase
    end
  end

  assign axil.rvalid = rvalid_q;
  assign axil.rdata  = rdata_q;
  assign axil.rresp  = bridge_pkg::RESP_OKAY;

  // Counter controls
  assign count_en_o   = ctrl_q[bridge_pkg::CTRL_EN_BIT];
  assign count_step_o = ctrl_q[bridge_pkg::CTRL_STEP_LSB +: bridge_pkg::CTRL_STEP_W];

  a_bvalid_after_write: assert property (
    @(posedge aclk) disable iff (!aresetn)
    $rose(axil.bvalid) |-> $past(axil.awvalid & axil.awready & axil.wvalid & axil.wready)
  );

  a_rvalid_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (axil.rvalid & ~axil.rready) |=> axil.rvalid & $stable(axil.rdata)
  );

endmodule

//--- hw/axil_subsys_top.sv
// --------------------
// Peripheral top, Avalon-MM host port to registers and counter
// --------------------
module axil_subsys_top (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic [bridge_pkg::ADDR_W-1:0]   avmm_address_i,
  input  logic [bridge_pkg::DATA_W-1:0]   avmm_writedata_i,
  input  logic [bridge_pkg::STRB_W-1:0]   avmm_byteenable_i,
  input  logic                            avmm_read_i,
  input  logic                            avmm_write_i,
  output logic [bridge_pkg::DATA_W-1:0]   avmm_readdata_o,
  output logic                            avmm_waitrequest_o,
  output logic                            avmm_readdata_valid_o
);

  logic                               count_en;
  logic [bridge_pkg::CTRL_STEP_W-1:0] count_step;
  logic [bridge_pkg::DATA_W-1:0]      count_value;

  // Internal AXI4-Lite link
  axil_if i_axil ();

  // --------------------
  // Bridge
  // --------------------
  avmm_axil_bridge i_bridge (
    .aclk                  (aclk),
    .aresetn               (aresetn),
    .avmm_address_i        (avmm_address_i),
    .avmm_writedata_i      (avmm_writedata_i),
    .avmm_byteenable_i     (avmm_byteenable_i),
    .avmm_read_i           (avmm_read_i),
    .avmm_write_i          (avmm_write_i),
    .avmm_readdata_o       (avmm_readdata_o),
    .avmm_waitrequest_o    (avmm_waitrequest_o),
    .avmm_readdata_valid_o (avmm_readdata_valid_o),
    .axil                  (i_axil.master)
  );

  // --------------------
  // Registers and counter
  // --------------------
  axil_regs i_regs (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .axil          (i_axil.slave),
    .count_value_i (count_value),
    .count_en_o    (count_en),
    .count_step_o  (count_step)
  );

  event_counter i_counter (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .count_en_i    (count_en),
    .count_step_i  (count_step),
    .count_value_o (count_value)
  );

endmodule

//--- hw/event_counter.sv
// --------------------
// Event counter, adds a step each cycle while enabled
// --------------------
module event_counter (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic                               count_en_i,
  input  logic [bridge_pkg::CTRL_STEP_W-1:0] count_step_i,
  output logic [bridge_pkg::DATA_W-1:0]      count_value_o
);

  logic [bridge_pkg::DATA_W-1:0] count_q;
  logic [bridge_pkg::DATA_W-1:0] step_ext;

  // Step widened to the counter width
  assign step_ext = {{(bridge_pkg::DATA_W - bridge_pkg::CTRL_STEP_W){1'b0}}, count_step_i};

  // --------------------
  // Count register
  // --------------------
  // Wraps modulo 2^32, holds while disabled
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      count_q <= '0;
    end else if (count_en_i) begin
      count_q <= count_q + step_ext;
    end
  end

  assign count_value_o = count_q;

endmodule

//--- verif/tb_checker.sv
// --------------------
// Avalon port monitor, register model and read data compare
// --------------------
module tb_checker (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [bridge_pkg::ADDR_W-1:0] avmm_address_i,
  input  logic [bridge_pkg::DATA_W-1:0] avmm_writedata_i,
  input  logic [bridge_pkg::STRB_W-1:0] avmm_byteenable_i,
  input  logic                          avmm_read_i,
  input  logic                          avmm_write_i,
  input  logic [bridge_pkg::DATA_W-1:0] avmm_readdata_i,
  input  logic                          avmm_waitrequest_i,
  input  logic                          avmm_readdata_valid_i,
  output int                            checks_o,
  output int                            errors_o
);

  logic [31:0] reg_model [4];
  logic [31:0] last_count;
  logic        count_known;
  logic        wait_prev;
  logic        accept_prev;
  logic        rd_pending;
  logic [1:0]  rd_idx;
  logic [1:0]  rd_off;

  function automatic string reg_name(input logic [1:0] idx);
    case (idx)
      bridge_pkg::REG_SCRATCH0: return "SCRATCH0";
      bridge_pkg::REG_SCRATCH1: return "SCRATCH1";
      bridge_pkg::REG_CTRL:     return "CTRL";
      default:                  return "COUNT";
    endcase
  endfunction

  // Byte enables and data move up by the byte offset, upper lanes fall off
  function automatic logic [31:0] apply_write(
    input logic [31:0] old_val,
    input logic [31:0] data,
    input logic [3:0]  be,
    input logic [1:0]  off
  );
    logic [31:0] result;
    logic [31:0] shifted;
    logic [3:0]  lanes;
    result  = old_val;
    shifted = data << (8 * off);
    lanes   = be << off;
    for (int lane = 0; lane < 4; lane++) begin
      if (lanes[lane]) begin
        result[8*lane +: 8] = shifted[8*lane +: 8];
      end
    end
    return result;
  endfunction

  // Host view of a stored word read at a byte offset
  function automatic logic [31:0] read_view(input logic [31:0] word, input logic [1:0] off);
    logic [31:0] view;
    view = word >> (8 * off);
    // Offset 1 keeps only two bytes
    if (off == 2'd1) begin
      view = view & 32'h0000_ffff;
    end
    return view;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks_o++;
    if (act !== exp) begin
      errors_o++;
      $display("[FAIL] %0t %s: expected %08h, got %08h", $time, name, exp, act);
    end
  endtask

  // Host must be held off from the cycle after acceptance
  task automatic check_stall();
    checks_o++;
    if (!avmm_waitrequest_i) begin
      errors_o++;
      $display("[FAIL] %0t waitrequest low in the cycle after acceptance", $time);
    end
  endtask

  // --------------------
  // Count register
  // --------------------
  task automatic check_count(input logic [31:0] actual);
    logic [31:0] step;
    logic [31:0] delta;
    logic        frozen;
    step = '0;
    step[bridge_pkg::CTRL_STEP_W-1:0] =
      reg_model[bridge_pkg::REG_CTRL][bridge_pkg::CTRL_STEP_LSB +: bridge_pkg::CTRL_STEP_W];
    frozen = !reg_model[bridge_pkg::REG_CTRL][bridge_pkg::CTRL_EN_BIT] || (step == 0);
    delta  = actual - last_count;
    if (frozen && count_known) begin
      compare_word("COUNT", read_view(last_count, rd_off), actual);
    end else if (rd_off != 2'd0) begin
      // A shifted view of a running count loses the baseline
      count_known = 1'b0;
    end else begin
      if (!frozen && count_known) begin
        checks_o++;
        if ((delta % step) != 0) begin
          errors_o++;
          $display("[FAIL] %0t COUNT: advanced by %08h, not a multiple of step %0d",
                   $time, delta, step);
        end
      end
      last_count  = actual;
      count_known = 1'b1;
    end
  endtask

  task automatic check_read(input logic [31:0] actual);
    if (!rd_pending) begin
      errors_o++;
      $display("ERROR: readdatavalid at time %0t with no read outstanding", $time);
    end else if (rd_idx == bridge_pkg::REG_COUNT) begin
      check_count(actual);
    end else begin
      compare_word(reg_name(rd_idx), read_view(reg_model[rd_idx], rd_off), actual);
    end
    rd_pending = 1'b0;
  endtask

  task automatic record_command();
    logic [1:0] idx;
    logic [1:0] off;
    idx = avmm_address_i[3:2];
    off = avmm_address_i[1:0];
    if (avmm_write_i) begin
      if (idx != bridge_pkg::REG_COUNT) begin
        reg_model[idx] = apply_write(reg_model[idx], avmm_writedata_i, avmm_byteenable_i, off);
      end
      if (idx == bridge_pkg::REG_CTRL) begin
        reg_model[idx] = reg_model[idx] & bridge_pkg::CTRL_MASK;
        count_known    = 1'b0;
      end
    end else begin
      rd_pending = 1'b1;
      rd_idx     = idx;
      rd_off     = off;
    end
  endtask

  // --------------------
  // Mid-cycle sampling
  // --------------------
  // A cycle right after waitrequest drops carries the response
  always @(negedge aclk) begin
    if (!aresetn) begin
      for (int r = 0; r < 4; r++) begin
        reg_model[r] = '0;
      end
      last_count  = '0;
      count_known = 1'b1;
      wait_prev   = 1'b0;
      accept_prev = 1'b0;
      rd_pending  = 1'b0;
    end else begin
      if (accept_prev) begin
        check_stall();
      end
      if (avmm_readdata_valid_i) begin
        check_read(avmm_readdata_i);
      end
      accept_prev = (avmm_read_i || avmm_write_i) && !avmm_waitrequest_i && !wait_prev;
      if (accept_prev) begin
        record_command();
      end
      wait_prev = avmm_waitrequest_i;
    end
  end

endmodule

//--- verif/tb_top.sv
// --------------------
// Testbench top, random Avalon-MM traffic into the peripheral
// --------------------
module tb_top;

  localparam logic [31:0] SEED       = 32'd53627;
  localparam int          NUM_CMDS   = 400;
  localparam int          WAIT_LIMIT = 50;

  logic                          aclk;
  logic                          aresetn;
  logic [bridge_pkg::ADDR_W-1:0] avmm_address;
  logic [bridge_pkg::DATA_W-1:0] avmm_writedata;
  logic [bridge_pkg::STRB_W-1:0] avmm_byteenable;
  logic                          avmm_read;
  logic                          avmm_write;
  logic [bridge_pkg::DATA_W-1:0] avmm_readdata;
  logic                          avmm_waitrequest;
  logic                          avmm_readdata_valid;
  logic [31:0]                   rng;
  logic                          wait_now;
  logic                          wait_prev;
  logic                          hung;
  logic                          is_read;
  logic [1:0]                    idx;
  logic [1:0]                    off;
  logic [3:0]                    be;
  int                            timeouts;
  int                            checks;
  int                            errors;

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  axil_subsys_top i_dut (
    .aclk                  (aclk),
    .aresetn               (aresetn),
    .avmm_address_i        (avmm_address),
    .avmm_writedata_i      (avmm_writedata),
    .avmm_byteenable_i     (avmm_byteenable),
    .avmm_read_i           (avmm_read),
    .avmm_write_i          (avmm_write),
    .avmm_readdata_o       (avmm_readdata),
    .avmm_waitrequest_o    (avmm_waitrequest),
    .avmm_readdata_valid_o (avmm_readdata_valid)
  );

  tb_checker i_chk (
    .aclk                  (aclk),
    .aresetn               (aresetn),
    .avmm_address_i        (avmm_address),
    .avmm_writedata_i      (avmm_writedata),
    .avmm_byteenable_i     (avmm_byteenable),
    .avmm_read_i           (avmm_read),
    .avmm_write_i          (avmm_write),
    .avmm_readdata_i       (avmm_readdata),
    .avmm_waitrequest_i    (avmm_waitrequest),
    .avmm_readdata_valid_i (avmm_readdata_valid),
    .checks_o              (checks),
    .errors_o              (errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------
  // Host side waits
  // --------------------
  // Mid-cycle sample, keeps the waitrequest of the cycle before
  task automatic next_sample();
    wait_prev = wait_now;
    @(negedge aclk);
    wait_now = avmm_waitrequest;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    hung = 1'b1;
    $display("ERROR: DUT stopped responding while waiting for %s at time %0t", what, $time);
  endtask

  // No acceptance in the cycle after a response
  task automatic wait_accept();
    int n;
    n = 0;
    next_sample();
    while ((wait_now || wait_prev) && !hung) begin
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("command acceptance");
      end else begin
        next_sample();
      end
    end
  endtask

  task automatic wait_readdata();
    int n;
    n = 0;
    next_sample();
    while (!avmm_readdata_valid && !hung) begin
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("readdatavalid");
      end else begin
        next_sample();
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    next_sample();
    while (wait_now && !hung) begin
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("waitrequest to drop");
      end else begin
        next_sample();
      end
    end
  endtask

  task automatic run_command(
    input logic                          rd,
    input logic [bridge_pkg::ADDR_W-1:0] addr,
    input logic [bridge_pkg::DATA_W-1:0] data,
    input logic [bridge_pkg::STRB_W-1:0] strb
  );
    @(posedge aclk);
    avmm_address    <= addr;
    avmm_writedata  <= data;
    avmm_byteenable <= strb;
    avmm_read       <= rd;
    avmm_write      <= ~rd;
    wait_accept();
    @(posedge aclk);
    avmm_read  <= 1'b0;
    avmm_write <= 1'b0;
    if (rd && !hung) begin
      wait_readdata();
    end
    if (!hung) begin
      wait_idle();
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    aresetn         = 1'b0;
    avmm_address    = '0;
    avmm_writedata  = '0;
    avmm_byteenable = '0;
    avmm_read       = 1'b0;
    avmm_write      = 1'b0;
    rng             = SEED;
    wait_now        = 1'b0;
    wait_prev       = 1'b0;
    hung            = 1'b0;
    timeouts        = 0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;

    // Reset values of all four registers first
    for (int r = 0; r < 4 && !hung; r++) begin
      run_command(1'b1, {28'b0, 2'(r), 2'b00}, '0, 4'hf);
    end

    for (int i = 0; i < NUM_CMDS && !hung; i++) begin
      rng     = xorshift32(rng);
      is_read = rng[0];
      idx     = rng[2:1];
      off     = rng[4:3];
      be      = rng[5] ? 4'hf : rng[9:6];
      // Count reads mostly word aligned so the step check gets samples
      if (is_read && idx == bridge_pkg::REG_COUNT && rng[10]) begin
        off = 2'd0;
      end
      // Upper address bits alias onto the same registers
      run_command(is_read, {rng[31:20], 16'h0000, idx, off}, xorshift32(rng), be);
      rng = xorshift32(rng);
    end

    repeat (4) @(posedge aclk);
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
